// File: verilog.f
+incdir+.
fetch_pkg.sv
rvc_expand.sv
insn_align.sv
fetch_pc_seq.sv
fetch_top.sv
fetch_asserts.sv
fetch_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f verilog.f \
    -o sim_fetch || exit 1
./obj_dir/sim_fetch | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run passed" || { echo "run failed"; exit 1; }

// File: fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;

    localparam logic [31:0] BASE = `FETCH_RESET_PC;
    localparam int NUM_C = 8;

    logic                 clk_i;
    logic                 rst_i;
    logic                 stall_i;
    logic                 mem_wait_i;
    fetch_pkg::word_t     mem_data_i;
    fetch_pkg::redirect_t redirect_i;
    fetch_pkg::pc_t       fetch_addr_o;
    fetch_pkg::issue_t    issue_o;
    logic                 ready_o;

    fetch_pkg::half_t  mem [0:255];       // halfwords from BASE on
    fetch_pkg::half_t  c_parcel [0:NUM_C-1];
    fetch_pkg::word_t  c_insn [0:NUM_C-1]; // expansion of each parcel
    logic [31:0]       exp_pc;            // byte address of the next instruction
    logic              split_wait;        // first half of a split taken, nothing issued yet
    fetch_pkg::pc_t    prev_addr;
    fetch_pkg::issue_t prev_issue;

    fetch_top fetch_top_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .mem_wait_i   (mem_wait_i),
        .mem_data_i   (mem_data_i),
        .redirect_i   (redirect_i),
        .fetch_addr_o (fetch_addr_o),
        .issue_o      (issue_o),
        .ready_o      (ready_o)
    );

    bind fetch_top fetch_asserts fetch_asserts_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .mem_wait_i   (mem_wait_i),
        .redirect_i   (redirect_i),
        .fetch_addr_i (fetch_addr_o),
        .issue_i      (issue_o),
        .ready_i      (ready_o)
    );

    // word read, same cycle as the address
    assign mem_data_i = {mem[{fetch_addr_o[8:2], 1'b1}], mem[{fetch_addr_o[8:2], 1'b0}]};

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic check_record(input fetch_pkg::word_t insn, input logic [31:0] pc,
                                input logic [31:0] pc_next);
        check_word("issue_o.insn", issue_o.insn, insn);
        check_word("issue_o.pc", {issue_o.pc, 1'b0}, pc);
        check_word("issue_o.pc_next", {issue_o.pc_next, 1'b0}, pc_next);
    endtask

    function automatic fetch_pkg::half_t half_at(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - BASE;
        return mem[off[8:1]];
    endfunction

    function automatic fetch_pkg::word_t expansion_of(input fetch_pkg::half_t parcel);
        fetch_pkg::word_t result;
        result = '0;
        for (int i = 0; i < NUM_C; i++) begin
            if (c_parcel[i] == parcel) begin
                result = c_insn[i];
            end
        end
        return result;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, 8'h13}; // filler beyond the program
        end
        c_parcel = '{16'h450d, 16'h85aa, 16'h952e, 16'h157d,
                     16'h050a, 16'h4150, 16'h0001, 16'h9002};
        // li a0,3 / mv a1,a0 / add a0,a1 / addi a0,-1 / slli a0,2 / lw a2,4(a0) / nop / ebreak
        c_insn = '{32'h0030_0513, 32'h00a0_05b3, 32'h00b5_0533, 32'hfff5_0513,
                   32'h0025_1513, 32'h0045_2603, 32'h0000_0013, 32'h0010_0073};
        mem[0]  = 16'h0093; // addi x1, x0, 5
        mem[1]  = 16'h0050;
        mem[2]  = 16'h8133; // add x2, x1, x1
        mem[3]  = 16'h0010;
        mem[4]  = c_parcel[0];
        mem[5]  = c_parcel[1];
        mem[6]  = c_parcel[2];
        mem[7]  = 16'h01b3; // sub x3, x2, x1 across a word boundary
        mem[8]  = 16'h4011;
        mem[9]  = c_parcel[3];
        mem[10] = c_parcel[4];
        mem[11] = 16'h62b3; // or x5, x6, x7, split again
        mem[12] = 16'h0073;
        mem[13] = c_parcel[5];
        mem[14] = c_parcel[6];
        mem[15] = c_parcel[7];
        mem[16] = 16'h0533; // add x10, x10, x11
        mem[17] = 16'h00b5;
    endtask

    // one cycle from the drive point to the next one; issued marks a new record
    task automatic run_cycle(input logic st, input logic mw, input logic rv,
                             input logic [31:0] tgt, output logic issued);
        fetch_pkg::half_t lo;
        logic [31:0]      size;
        stall_i           = st;
        mem_wait_i        = mw;
        redirect_i.valid  = rv;
        redirect_i.target = tgt[31:1];
        issued            = 1'b0;
        @(negedge clk_i);
        check_word("ready_o", {31'd0, ready_o}, {31'd0, !mw && !split_wait});
        prev_addr  = fetch_addr_o;
        prev_issue = issue_o;
        @(posedge clk_i);
        #1;
        lo   = half_at(exp_pc);
        size = (lo[1:0] != 2'b11) ? 32'd2 : 32'd4;
        if (rv && !st) begin
            check_word("fetch_addr_o", {fetch_addr_o, 1'b0}, tgt);
            check_word("issue_o.insn", issue_o.insn, `FETCH_EBREAK);
            exp_pc     = tgt;
            split_wait = 1'b0;
        end else if (st || mw || (exp_pc[1] && size == 32'd4 && !split_wait)) begin
            // plain hold, or the first edge of a split instruction
            if (!st && !mw) begin
                split_wait = 1'b1;
            end else begin
                check_word("fetch_addr_o", {fetch_addr_o, 1'b0}, {prev_addr, 1'b0});
            end
            check_record(prev_issue.insn, {prev_issue.pc, 1'b0}, {prev_issue.pc_next, 1'b0});
        end else begin
            if (size == 32'd2) begin
                check_record(expansion_of(lo), exp_pc, exp_pc + 32'd2);
            end else begin
                check_record({half_at(exp_pc + 32'd2), lo}, exp_pc, exp_pc + 32'd4);
            end
            exp_pc     = exp_pc + size;
            split_wait = 1'b0;
            issued     = 1'b1;
        end
        #1;
    endtask

    task automatic issue_next();
        logic issued;
        int   waited;
        issued = 1'b0;
        waited = 0;
        while (!issued) begin
            if (waited > 64) begin
                abort_run("no instruction issued within 64 cycles");
            end
            run_cycle(($urandom % 5) == 0, ($urandom % 4) == 0, 1'b0, 32'd0, issued);
            waited++;
        end
    endtask

    task automatic walk_to(input logic [31:0] limit);
        for (int n = 0; n < 32 && exp_pc < limit; n++) begin
            issue_next();
        end
        if (exp_pc != limit) begin
            abort_run("program walk did not reach its end address");
        end
    endtask

    task automatic redirect_to(input logic [31:0] tgt);
        logic issued;
        run_cycle(1'b0, ($urandom % 2) == 0, 1'b1, tgt, issued);
    endtask

    initial begin
        void'($urandom(32'h7602_67b8));
        rst_i      = 1'b1;
        stall_i    = 1'b0;
        mem_wait_i = 1'b0;
        redirect_i = '0;
        exp_pc     = BASE;
        split_wait = 1'b0;
        load_program();
        for (int n = 0; n < 10; n++) begin
            @(posedge clk_i);
        end
        #1;
        check_word("fetch_addr_o", {fetch_addr_o, 1'b0}, BASE);
        check_word("issue_o.insn", issue_o.insn, `FETCH_EBREAK);
        check_word("ready_o", {31'd0, ready_o}, 32'd1);
        #1;
        rst_i = 1'b0;
        walk_to(BASE + 32'd36);
        redirect_to(BASE + 32'd10);
        walk_to(BASE + 32'd26);
        redirect_to(BASE + 32'd22); // lands on a split instruction
        walk_to(BASE + 32'd36);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: fetch_asserts.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_asserts (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 stall_i,
    input logic                 mem_wait_i,
    input fetch_pkg::redirect_t redirect_i,
    input fetch_pkg::pc_t       fetch_addr_i,
    input fetch_pkg::issue_t    issue_i,
    input logic                 ready_i
);

    localparam fetch_pkg::word_t RESET_BYTE = `FETCH_RESET_PC;

    logic           armed = 1'b0; // a reset has been seen
    logic           redir;        // redirect that takes effect this edge
    fetch_pkg::pc_t target;

    assign redir  = redirect_i.valid & ~stall_i;
    assign target = redirect_i.target;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            armed <= 1'b1;
        end
    end

    reset_values: assert property (@(posedge clk_i)
        armed && $past(rst_i) |-> fetch_addr_i == RESET_BYTE[31:1]
            && issue_i.insn == `FETCH_EBREAK)
        else $error("fetch state after reset is wrong");

    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        armed && !$past(rst_i) && $past(stall_i) |-> $stable(fetch_addr_i) && $stable(issue_i))
        else $error("address or issue record moved during a stall");

    // memory wait holds everything except a redirect
    wait_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        armed && !$past(rst_i) && $past(mem_wait_i) && !$past(redir)
            |-> $stable(fetch_addr_i) && $stable(issue_i))
        else $error("address or issue record moved while memory was waiting");

    redirect_load: assert property (@(posedge clk_i) disable iff (rst_i)
        armed && !$past(rst_i) && $past(redir)
            |-> fetch_addr_i == $past(target) && issue_i.insn == `FETCH_EBREAK)
        else $error("redirect did not load the target with a bubble");

    // ready low with memory valid means a split is pending, so the address holds
    addr_step: assert property (@(posedge clk_i) disable iff (rst_i)
        armed && !$past(rst_i) && !$past(stall_i) && !$past(mem_wait_i)
            && !$past(redirect_i.valid)
            |-> $past(ready_i)
                ? (fetch_addr_i == $past(fetch_addr_i) + 31'd1
                   || fetch_addr_i == $past(fetch_addr_i) + 31'd2)
                : fetch_addr_i == $past(fetch_addr_i))
        else $error("fetch address stepped by something other than 2 or 4 bytes");

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 mem_wait_i,
    input  fetch_pkg::word_t     mem_data_i,
    input  fetch_pkg::redirect_t redirect_i,
    output fetch_pkg::pc_t       fetch_addr_o,
    output fetch_pkg::issue_t    issue_o,
    output logic                 ready_o
);

    fetch_pkg::step_t step;
    fetch_pkg::half_t half;     // parcel to expand
    fetch_pkg::word_t expanded;

    fetch_pc_seq fetch_pc_seq_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .step_i     (step),
        .redirect_i (redirect_i),
        .stall_i    (stall_i),
        .pc_o       (fetch_addr_o)
    );

    insn_align insn_align_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .mem_wait_i       (mem_wait_i),
        .mem_data_i       (mem_data_i),
        .pc_i             (fetch_addr_o),
        .redirect_valid_i (redirect_i.valid),
        .expanded_i       (expanded),
        .half_o           (half),
        .step_o           (step),
        .issue_o          (issue_o),
        .ready_o          (ready_o)
    );

    rvc_expand rvc_expand_inst (
        .half_i (half),
        .insn_o (expanded)
    );

endmodule

// File: fetch_pc_seq.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_pc_seq (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  fetch_pkg::step_t     step_i,
    input  fetch_pkg::redirect_t redirect_i,
    input  logic                 stall_i,
    output fetch_pkg::pc_t       pc_o
);

    localparam fetch_pkg::word_t RESET_BYTE = `FETCH_RESET_PC;

    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t pc_step;

    // one halfword for a compressed parcel, two for a full word
    assign pc_step = pc_q + (step_i.size_c ? 31'd1 : 31'd2);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_BYTE[31:1];
        end else if (!stall_i) begin
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target; // taken even while memory waits
            end else if (step_i.advance && !step_i.hold) begin
                pc_q <= pc_step;
            end
        end
    end

    assign pc_o = pc_q;

endmodule

// File: insn_align.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_align (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              mem_wait_i,
    input  fetch_pkg::word_t  mem_data_i,
    input  fetch_pkg::pc_t    pc_i,
    input  logic              redirect_valid_i,
    input  fetch_pkg::word_t  expanded_i,
    output fetch_pkg::half_t  half_o,
    output fetch_pkg::step_t  step_o,
    output fetch_pkg::issue_t issue_o,
    output logic              ready_o
);

    localparam fetch_pkg::word_t RESET_BYTE = `FETCH_RESET_PC;

    fetch_pkg::half_t  buf_q;     // first half of a split instruction
    logic              pending_q; // waiting for the second half
    fetch_pkg::issue_t issue_q;
    fetch_pkg::issue_t issue_d;
    fetch_pkg::pc_t    pc_inc;
    logic              aligned;
    logic              advance;
    logic              compressed;
    logic              split_start;

    assign aligned     = ~pc_i[1];
    assign advance     = ~stall_i & ~mem_wait_i;
    assign half_o      = aligned ? mem_data_i[15:0] : mem_data_i[31:16];
    assign compressed  = ~pending_q & (half_o[1:0] != 2'b11);
    assign split_start = ~pending_q & ~aligned & ~compressed; // 32-bit in upper half
    assign pc_inc      = pc_i + (compressed ? 31'd1 : 31'd2);

    assign step_o.advance = advance;
    assign step_o.hold    = pending_q; // fetch address already points past the split
    assign step_o.size_c  = compressed;

    always_comb begin
        issue_d.pc      = pc_i;
        issue_d.pc_next = pc_inc;
        if (pending_q) begin
            // fetch address ran one word ahead while the first half was kept
            issue_d.insn    = {mem_data_i[15:0], buf_q};
            issue_d.pc      = pc_i - 31'd2;
            issue_d.pc_next = pc_i;
        end else if (compressed) begin
            issue_d.insn = expanded_i;
        end else begin
            issue_d.insn = mem_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q       <= 1'b0;
            buf_q           <= '0;
            issue_q.insn    <= `FETCH_EBREAK;
            issue_q.pc      <= RESET_BYTE[31:1];
            issue_q.pc_next <= RESET_BYTE[31:1];
        end else if (redirect_valid_i && !stall_i) begin
            pending_q    <= 1'b0;
            issue_q.insn <= `FETCH_EBREAK; // bubble while the new target is fetched
        end else if (advance) begin
            pending_q <= split_start;
            if (split_start) begin
                buf_q <= mem_data_i[31:16]; // nothing issued this edge
            end else begin
                issue_q <= issue_d;
            end
        end
    end

    assign issue_o = issue_q;
    assign ready_o = ~mem_wait_i & ~pending_q;

endmodule

// File: rvc_expand.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module rvc_expand (
    input  fetch_pkg::half_t half_i,
    output fetch_pkg::word_t insn_o
);

    fetch_pkg::half_t c; // short name keeps the bit fields readable

    assign c = half_i;

    // priority matters: ebreak before jalr/add, jr before mv
    always_comb begin
        casez (c)
            `C_EBREAK: begin
                insn_o = `FETCH_EBREAK;
            end
            `C_JR: begin // jalr x0, rs1, 0
                insn_o = {12'b0, c[11:7], 3'b000, 5'd0, 7'h67};
            end
            `C_JALR: begin // jalr x1, rs1, 0
                insn_o = {12'b0, c[11:7], 3'b000, 5'd1, 7'h67};
            end
            `C_NOP,
            `C_ADDI: begin // addi rd, rd, imm
                insn_o = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], 7'h13};
            end
            `C_ADDI16SP: begin // addi x2, x2, nzimm
                insn_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                          5'd2, 3'b000, 5'd2, 7'h13};
            end
            `C_AND: begin
                insn_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111, 2'b01, c[9:7], 7'h33};
            end
            `C_SUB: begin
                insn_o = {7'b0100000, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                          2'b01, c[9:7], 7'h33};
            end
            `C_OR: begin
                insn_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110, 2'b01, c[9:7], 7'h33};
            end
            `C_XOR: begin
                insn_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100, 2'b01, c[9:7], 7'h33};
            end
            `C_SRLI,
            `C_SRAI: begin // bit 10 selects the arithmetic shift
                insn_o = {1'b0, c[10], 5'b00000, c[6:2], 2'b01, c[9:7], 3'b101,
                          2'b01, c[9:7], 7'h13};
            end
            `C_ANDI: begin
                insn_o = {{7{c[12]}}, c[6:2], 2'b01, c[9:7], 3'b111, 2'b01, c[9:7], 7'h13};
            end
            `C_MV: begin // add rd, x0, rs2
                insn_o = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], 7'h33};
            end
            `C_SLLI: begin
                insn_o = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], 7'h13};
            end
            `C_ADD: begin
                insn_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], 7'h33};
            end
            `C_ADDI4SPN: begin // addi rd', x2, nzuimm
                insn_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                          5'd2, 3'b000, 2'b01, c[4:2], 7'h13};
            end
            `C_BEQZ,
            `C_BNEZ: begin // bit 13 picks bne over beq
                insn_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7], 2'b00, c[13],
                          c[11:10], c[4:3], c[12], 7'h63};
            end
            `C_J,
            `C_JAL: begin // rd is x1 only for c.jal
                insn_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                          {9{c[12]}}, 4'b0000, ~c[15], 7'h6f};
            end
            `C_LI: begin // addi rd, x0, imm
                insn_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7], 7'h13};
            end
            `C_LUI: begin
                insn_o = {{15{c[12]}}, c[6:2], c[11:7], 7'h37};
            end
            `C_LW: begin
                insn_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                          2'b01, c[4:2], 7'h03};
            end
            `C_LWSP: begin
                insn_o = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7], 7'h03};
            end
            `C_SW: begin
                insn_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                          c[11:10], c[6], 2'b00, 7'h23};
            end
            `C_SWSP: begin
                insn_o = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00, 7'h23};
            end
            default: begin
                insn_o = '0; // not a supported encoding
            end
        endcase
    end

endmodule

// File: fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] word_t; // instruction or memory word
    typedef logic [`FETCH_HALF-1:0] half_t; // one 16-bit parcel
    typedef logic [`FETCH_XLEN-1:1] pc_t;   // halfword address, byte bit 0 dropped

    // request from execute
    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

    // record handed to decode
    typedef struct packed {
        word_t insn;
        pc_t   pc;
        pc_t   pc_next;
    } issue_t;

    // aligner to sequencer
    typedef struct packed {
        logic advance; // registers update this cycle
        logic hold;    // next parcel already sits in the fetched word
        logic size_c;  // current instruction is compressed
    } step_t;

endpackage

// File: fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define FETCH_RESET_PC 32'h4000_0000
`define FETCH_EBREAK   32'h0010_0073 // also used as the pipeline bubble
`define FETCH_XLEN     32
`define FETCH_HALF     16

// compressed encodings, checked in this order by the expander
`define C_EBREAK   16'b1001_0000_0000_0010
`define C_JR       16'b1000_????_?000_0010
`define C_JALR     16'b1001_????_?000_0010
`define C_NOP      16'b0000_0000_0000_0001
`define C_ADDI16SP 16'b011?_0001_0???_??01
`define C_AND      16'b1000_11??_?11?_??01
`define C_SUB      16'b1000_11??_?00?_??01
`define C_OR       16'b1000_11??_?10?_??01
`define C_XOR      16'b1000_11??_?01?_??01
`define C_SRLI     16'b100?_00??_????_??01
`define C_SRAI     16'b100?_01??_????_??01
`define C_ANDI     16'b100?_10??_????_??01
`define C_MV       16'b1000_????_????_??10
`define C_SLLI     16'b000?_????_????_??10
`define C_ADD      16'b1001_????_????_??10
`define C_ADDI     16'b000?_????_????_??01
`define C_ADDI4SPN 16'b000?_????_????_??00
`define C_BEQZ     16'b110?_????_????_??01
`define C_BNEZ     16'b111?_????_????_??01
`define C_J        16'b101?_????_????_??01
`define C_JAL      16'b001?_????_????_??01
`define C_LI       16'b010?_????_????_??01
`define C_LUI      16'b011?_????_????_??01
`define C_LW       16'b010?_????_????_??00
`define C_LWSP     16'b010?_????_????_??10
`define C_SW       16'b110?_????_????_??00
`define C_SWSP     16'b110?_????_????_??10

`endif
